//--- compile.f
verilog/riscv_mw_pkg.sv
verilog/riscv_mw_wb_if.sv
verilog/riscv_mw_memdecode.sv
verilog/riscv_mw_ppreg.sv
verilog/riscv_mw_wbresult.sv
verilog/riscv_mw_top.sv
test/riscv_mw_checker.sv
test/riscv_mw_tb.sv

//--- test/riscv_mw_tb.sv
`default_nettype none

module riscv_mw_tb;

    localparam int num_cycles = 600;

    typedef struct packed {
        logic [63:0] pcplus4, result, uimm, csrout, rddata_sc, memrdata;
        logic [2:0]  byteoff, loadsize, resultsrc;
        logic [4:0]  rdaddr, rs1addr;
        logic        regw, iscsr, gototrap, returnfromtrap, instret;
    } stim_t;

    typedef struct packed {
        logic [63:0] pcplus4, result, uimm, memload, csrout, rddata_sc;
        logic [4:0]  rdaddr;
        logic [2:0]  resultsrc;
        logic        regw, iscsr, gototrap, returnfromtrap, instret;
    } stage_t;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    stim_t       drv;
    logic [63:0] wbdata;
    logic [63:0] rs1data;
    logic        regwe_wb;
    logic [4:0]  rdaddr_wb;
    logic        iscsr_wb;
    logic        gototrap_wb;
    logic        returnfromtrap_wb;
    logic        instret_wb;
    logic [15:0] instret_count;

    stage_t      sh;                  // shadow stage register
    logic [63:0] shadow_rf [0:31];
    logic [15:0] shadow_cnt;
    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          timeouts;

    riscv_mw_top #(
        .INSTRET_W (16)
    ) u_riscv_mw_top (
        .i_riscv_mw_clk               (clk),
        .i_riscv_mw_rst               (rst),
        .i_riscv_mw_stall             (stall),
        .i_riscv_mw_flush             (flush),
        .i_riscv_mw_memrdata_m        (drv.memrdata),
        .i_riscv_mw_byteoff_m         (drv.byteoff),
        .i_riscv_mw_loadsize_m        (drv.loadsize),
        .i_riscv_mw_pcplus4_m         (drv.pcplus4),
        .i_riscv_mw_result_m          (drv.result),
        .i_riscv_mw_uimm_m            (drv.uimm),
        .i_riscv_mw_csrout_m          (drv.csrout),
        .i_riscv_mw_rddata_sc_m       (drv.rddata_sc),
        .i_riscv_mw_rdaddr_m          (drv.rdaddr),
        .i_riscv_mw_resultsrc_m       (drv.resultsrc),
        .i_riscv_mw_regw_m            (drv.regw),
        .i_riscv_mw_iscsr_m           (drv.iscsr),
        .i_riscv_mw_gototrap_m        (drv.gototrap),
        .i_riscv_mw_returnfromtrap_m  (drv.returnfromtrap),
        .i_riscv_mw_instret_m         (drv.instret),
        .i_riscv_mw_rs1addr           (drv.rs1addr),
        .o_riscv_mw_wbdata            (wbdata),
        .o_riscv_mw_rs1data           (rs1data),
        .o_riscv_mw_regwe_wb          (regwe_wb),
        .o_riscv_mw_rdaddr_wb         (rdaddr_wb),
        .o_riscv_mw_iscsr_wb          (iscsr_wb),
        .o_riscv_mw_gototrap_wb       (gototrap_wb),
        .o_riscv_mw_returnfromtrap_wb (returnfromtrap_wb),
        .o_riscv_mw_instret_wb        (instret_wb),
        .o_riscv_mw_instret_count     (instret_count)
    );

    always #4 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [63:0] extract_load(input logic [63:0] raw, input logic [2:0] off,
                                                 input logic [2:0] size);
        riscv_mw_pkg::load_word_u word;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        word = raw;
        b = word.b[off];
        h = word.h[off[2:1]];
        w = word.w[off[2]];
        case (size)
            riscv_mw_pkg::lb:  return {{56{b[7]}}, b};
            riscv_mw_pkg::lh:  return {{48{h[15]}}, h};
            riscv_mw_pkg::lw:  return {{32{w[31]}}, w};
            riscv_mw_pkg::lbu: return {56'd0, b};
            riscv_mw_pkg::lhu: return {48'd0, h};
            riscv_mw_pkg::lwu: return {32'd0, w};
            default:           return raw;    // ld and code 7
        endcase
    endfunction

    function automatic logic [63:0] wb_value(input stage_t s);
        case (s.resultsrc)
            riscv_mw_pkg::res_alu:     return s.result;
            riscv_mw_pkg::res_load:    return s.memload;
            riscv_mw_pkg::res_pcplus4: return s.pcplus4;
            riscv_mw_pkg::res_uimm:    return s.uimm;
            riscv_mw_pkg::res_csr:     return s.csrout;
            riscv_mw_pkg::res_sc:      return s.rddata_sc;
            default:                   return 64'd0;
        endcase
    endfunction

    task automatic reset_model();
        sh = '0;
        shadow_cnt = '0;
        for (int i = 0; i < 32; i++) begin
            shadow_rf[i] = '0;
        end
    endtask

    // one rising edge of the stage and writeback rules
    task automatic step_model();
        if (sh.instret) shadow_cnt = shadow_cnt + 1'b1;
        if (sh.regw && !sh.gototrap && sh.rdaddr != 5'd0) shadow_rf[sh.rdaddr] = wb_value(sh);
        if (flush) begin
            sh = '0;
        end else if (!stall) begin
            sh.pcplus4        = drv.pcplus4;
            sh.result         = drv.result;
            sh.uimm           = drv.uimm;
            sh.memload        = extract_load(drv.memrdata, drv.byteoff, drv.loadsize);
            sh.csrout         = drv.csrout;
            sh.rddata_sc      = drv.rddata_sc;
            sh.rdaddr         = drv.rdaddr;
            sh.resultsrc      = drv.resultsrc;
            sh.regw           = drv.regw;
            sh.iscsr          = drv.iscsr;
            sh.gototrap       = drv.gototrap;
            sh.returnfromtrap = drv.returnfromtrap;
            sh.instret        = drv.instret;
        end else begin
            sh.instret = 1'b0;
        end
    endtask

    task automatic pick_stimulus(input logic quiet, output stim_t nxt, output logic nxt_stall,
                                 output logic nxt_flush);
        logic [63:0] v;
        nxt = '0;
        nxt_stall = 1'b0;
        nxt_flush = 1'b0;
        rand_bits(5, v);
        nxt.rs1addr = v[4:0];
        if (!quiet) begin
            rand_bits(3, v);
            nxt_stall = (v[2:0] == 3'd0);    // about 1 in 8
            rand_bits(3, v);
            nxt_flush = (v[2:0] == 3'd0);
            rand_bits(64, v);
            nxt.pcplus4 = v;
            rand_bits(64, v);
            nxt.result = v;
            rand_bits(64, v);
            nxt.uimm = v;
            rand_bits(64, v);
            nxt.csrout = v;
            rand_bits(64, v);
            nxt.rddata_sc = v;
            rand_bits(64, v);
            nxt.memrdata = v;
            rand_bits(3, v);
            nxt.byteoff = v[2:0];
            rand_bits(3, v);
            nxt.loadsize = v[2:0];
            rand_bits(3, v);
            nxt.resultsrc = v[2:0];
            rand_bits(2, v);
            if (v[1:0] != 2'd0) begin    // else rd stays x0
                rand_bits(5, v);
                nxt.rdaddr = v[4:0];
            end
            rand_bits(1, v);
            nxt.regw = v[0];
            rand_bits(2, v);
            nxt.gototrap = (v[1:0] == 2'd0);
            rand_bits(1, v);
            nxt.iscsr = v[0];
            rand_bits(1, v);
            nxt.returnfromtrap = v[0];
            rand_bits(1, v);
            nxt.instret = v[0];
        end
    endtask

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs();
        compare("wbdata", wbdata, wb_value(sh));
        compare("rs1data", rs1data, (drv.rs1addr == 5'd0) ? 64'd0 : shadow_rf[drv.rs1addr]);
        compare("regwe_wb", regwe_wb, sh.regw && !sh.gototrap && sh.rdaddr != 5'd0);
        compare("rdaddr_wb", rdaddr_wb, sh.rdaddr);
        compare("iscsr_wb", iscsr_wb, sh.iscsr);
        compare("gototrap_wb", gototrap_wb, sh.gototrap);
        compare("returnfromtrap_wb", returnfromtrap_wb, sh.returnfromtrap);
        compare("instret_wb", instret_wb, sh.instret);
        compare("instret_count", instret_count, shadow_cnt);
    endtask

    task automatic run_cycle(input logic nxt_rst, input logic quiet);
        stim_t nxt;
        logic  nxt_stall;
        logic  nxt_flush;
        @(posedge clk);
        if (rst) reset_model();
        else step_model();
        pick_stimulus(quiet, nxt, nxt_stall, nxt_flush);
        if (nxt_rst) reset_model();    // async, clears right after this edge
        rst   <= nxt_rst;
        stall <= nxt_stall;
        flush <= nxt_flush;
        drv   <= nxt;
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        logic drained;
        int   assert_fails;
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        drv = '0;
        lfsr_state = 32'h115d;
        checks = 0;
        errors = 0;
        timeouts = 0;
        reset_model();
        for (int i = 0; i < 16; i++) begin
            run_cycle(i < 15, 1'b1);
        end
        for (int c = 0; c < num_cycles; c++) begin
            run_cycle(c >= 300 && c < 304, 1'b0);    // second reset mid run
        end
        drained = 1'b0;
        for (int k = 0; k < 32 && !drained; k++) begin
            run_cycle(1'b0, 1'b1);
            drained = (instret_wb === 1'b0) && (regwe_wb === 1'b0);
        end
        if (!drained) begin
            timeouts++;
            $display("timeout: writeback stage still active after the drain cycles");
        end
        assert_fails = u_riscv_mw_top.u_ppreg.u_ppreg_checker.fail_count
                     + u_riscv_mw_top.u_wbresult.u_wbresult_checker.fail_count;
        $display("summary: %0d checks, %0d errors, %0d assertion failures, %0d timeouts",
                 checks, errors, assert_fails, timeouts);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/riscv_mw_checker.sv
`default_nettype none

module riscv_mw_checker #(
    parameter bit stage_side = 1'b1
) (
    input logic                          i_riscv_mw_clk,
    input logic                          i_riscv_mw_rst,
    input logic                          i_riscv_mw_stall,
    input logic                          i_riscv_mw_flush,
    input logic                          i_riscv_mw_regw,
    input logic                          i_riscv_mw_instret,
    input logic [4:0]                    i_riscv_mw_rs1addr,
    input logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_rs1data
);

    int unsigned fail_count = 0;    // summed by the testbench

    if (stage_side) begin : g_stage
        flush_clears: assert property (
            @(posedge i_riscv_mw_clk) disable iff (i_riscv_mw_rst)
            i_riscv_mw_flush |=> (!i_riscv_mw_regw && !i_riscv_mw_instret)
        ) else begin
            fail_count++;
            $error("flush left regw or instret set in the writeback slot");
        end

        // held slot retires only once
        stall_no_retire: assert property (
            @(posedge i_riscv_mw_clk) disable iff (i_riscv_mw_rst)
            i_riscv_mw_stall |=> !i_riscv_mw_instret
        ) else begin
            fail_count++;
            $error("instret still set after a stall");
        end
    end else begin : g_wb
        x0_reads_zero: assert property (
            @(posedge i_riscv_mw_clk) disable iff (i_riscv_mw_rst)
            (i_riscv_mw_rs1addr == 5'd0) |-> (i_riscv_mw_rs1data == '0)
        ) else begin
            fail_count++;
            $error("read of x0 returned a nonzero value");
        end
    end

endmodule

bind riscv_mw_ppreg riscv_mw_checker #(
    .stage_side (1'b1)
) u_ppreg_checker (
    .i_riscv_mw_clk     (i_riscv_mw_clk),
    .i_riscv_mw_rst     (i_riscv_mw_rst),
    .i_riscv_mw_stall   (i_riscv_mw_stall),
    .i_riscv_mw_flush   (i_riscv_mw_flush),
    .i_riscv_mw_regw    (wb.regw),
    .i_riscv_mw_instret (wb.instret),
    .i_riscv_mw_rs1addr (5'd0),    // no read port here
    .i_riscv_mw_rs1data ('0)
);

bind riscv_mw_wbresult riscv_mw_checker #(
    .stage_side (1'b0)
) u_wbresult_checker (
    .i_riscv_mw_clk     (i_riscv_mw_clk),
    .i_riscv_mw_rst     (i_riscv_mw_rst),
    .i_riscv_mw_stall   (1'b0),
    .i_riscv_mw_flush   (1'b0),
    .i_riscv_mw_regw    (wb.regw),
    .i_riscv_mw_instret (wb.instret),
    .i_riscv_mw_rs1addr (i_riscv_mw_rs1addr),
    .i_riscv_mw_rs1data (o_riscv_mw_rs1data)
);

`default_nettype wire

//--- verilog/riscv_mw_top.sv
`default_nettype none

module riscv_mw_top #(
    parameter int INSTRET_W = 64
) (
    input  logic                          i_riscv_mw_clk,
    input  logic                          i_riscv_mw_rst,
    input  logic                          i_riscv_mw_stall,
    input  logic                          i_riscv_mw_flush,
    // memory stage
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_memrdata_m,
    input  logic [2:0]                    i_riscv_mw_byteoff_m,
    input  logic [2:0]                    i_riscv_mw_loadsize_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_pcplus4_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_result_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_uimm_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_csrout_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_rddata_sc_m,
    input  logic [4:0]                    i_riscv_mw_rdaddr_m,
    input  logic [2:0]                    i_riscv_mw_resultsrc_m,
    input  logic                          i_riscv_mw_regw_m,
    input  logic                          i_riscv_mw_iscsr_m,
    input  logic                          i_riscv_mw_gototrap_m,
    input  logic                          i_riscv_mw_returnfromtrap_m,
    input  logic                          i_riscv_mw_instret_m,
    // register read port
    input  logic [4:0]                    i_riscv_mw_rs1addr,
    // writeback stage
    output logic [riscv_mw_pkg::xlen-1:0] o_riscv_mw_wbdata,
    output logic [riscv_mw_pkg::xlen-1:0] o_riscv_mw_rs1data,
    output logic                          o_riscv_mw_regwe_wb,
    output logic [4:0]                    o_riscv_mw_rdaddr_wb,
    output logic                          o_riscv_mw_iscsr_wb,
    output logic                          o_riscv_mw_gototrap_wb,
    output logic                          o_riscv_mw_returnfromtrap_wb,
    output logic                          o_riscv_mw_instret_wb,
    output logic [INSTRET_W-1:0]          o_riscv_mw_instret_count
);

    logic [riscv_mw_pkg::xlen-1:0] memload_m;    // aligned load value

    riscv_mw_wb_if u_wb_if ();

    riscv_mw_memdecode u_memdecode (
        .i_riscv_mw_memrdata_m (i_riscv_mw_memrdata_m),
        .i_riscv_mw_byteoff_m  (i_riscv_mw_byteoff_m),
        .i_riscv_mw_loadsize_m (i_riscv_mw_loadsize_m),
        .o_riscv_mw_memload_m  (memload_m)
    );

    riscv_mw_ppreg u_ppreg (
        .i_riscv_mw_clk              (i_riscv_mw_clk),
        .i_riscv_mw_rst              (i_riscv_mw_rst),
        .i_riscv_mw_stall            (i_riscv_mw_stall),
        .i_riscv_mw_flush            (i_riscv_mw_flush),
        .i_riscv_mw_pcplus4_m        (i_riscv_mw_pcplus4_m),
        .i_riscv_mw_result_m         (i_riscv_mw_result_m),
        .i_riscv_mw_uimm_m           (i_riscv_mw_uimm_m),
        .i_riscv_mw_memload_m        (memload_m),
        .i_riscv_mw_csrout_m         (i_riscv_mw_csrout_m),
        .i_riscv_mw_rddata_sc_m      (i_riscv_mw_rddata_sc_m),
        .i_riscv_mw_rdaddr_m         (i_riscv_mw_rdaddr_m),
        .i_riscv_mw_resultsrc_m      (i_riscv_mw_resultsrc_m),
        .i_riscv_mw_regw_m           (i_riscv_mw_regw_m),
        .i_riscv_mw_iscsr_m          (i_riscv_mw_iscsr_m),
        .i_riscv_mw_gototrap_m       (i_riscv_mw_gototrap_m),
        .i_riscv_mw_returnfromtrap_m (i_riscv_mw_returnfromtrap_m),
        .i_riscv_mw_instret_m        (i_riscv_mw_instret_m),
        .wb                          (u_wb_if.stage)
    );

    riscv_mw_wbresult #(
        .INSTRET_W (INSTRET_W)
    ) u_wbresult (
        .i_riscv_mw_clk               (i_riscv_mw_clk),
        .i_riscv_mw_rst               (i_riscv_mw_rst),
        .i_riscv_mw_rs1addr           (i_riscv_mw_rs1addr),
        .wb                           (u_wb_if.wb),
        .o_riscv_mw_wbdata            (o_riscv_mw_wbdata),
        .o_riscv_mw_rs1data           (o_riscv_mw_rs1data),
        .o_riscv_mw_regwe_wb          (o_riscv_mw_regwe_wb),
        .o_riscv_mw_rdaddr_wb         (o_riscv_mw_rdaddr_wb),
        .o_riscv_mw_iscsr_wb          (o_riscv_mw_iscsr_wb),
        .o_riscv_mw_gototrap_wb       (o_riscv_mw_gototrap_wb),
        .o_riscv_mw_returnfromtrap_wb (o_riscv_mw_returnfromtrap_wb),
        .o_riscv_mw_instret_wb        (o_riscv_mw_instret_wb),
        .o_riscv_mw_instret_count     (o_riscv_mw_instret_count)
    );

endmodule

`default_nettype wire

//--- verilog/riscv_mw_wbresult.sv
`default_nettype none

module riscv_mw_wbresult #(
    parameter int INSTRET_W = 64
) (
    input  logic                          i_riscv_mw_clk,
    input  logic                          i_riscv_mw_rst,
    input  logic [4:0]                    i_riscv_mw_rs1addr,
    riscv_mw_wb_if.wb                     wb,
    output logic [riscv_mw_pkg::xlen-1:0] o_riscv_mw_wbdata,
    output logic [riscv_mw_pkg::xlen-1:0] o_riscv_mw_rs1data,
    output logic                          o_riscv_mw_regwe_wb,
    output logic [4:0]                    o_riscv_mw_rdaddr_wb,
    output logic                          o_riscv_mw_iscsr_wb,
    output logic                          o_riscv_mw_gototrap_wb,
    output logic                          o_riscv_mw_returnfromtrap_wb,
    output logic                          o_riscv_mw_instret_wb,
    output logic [INSTRET_W-1:0]          o_riscv_mw_instret_count
);

    logic [riscv_mw_pkg::xlen-1:0] regs [0:31];
    logic                          rf_we;

    always_comb begin
        case (wb.resultsrc)
            riscv_mw_pkg::res_alu:     o_riscv_mw_wbdata = wb.result;
            riscv_mw_pkg::res_load:    o_riscv_mw_wbdata = wb.memload;
            riscv_mw_pkg::res_pcplus4: o_riscv_mw_wbdata = wb.pcplus4;
            riscv_mw_pkg::res_uimm:    o_riscv_mw_wbdata = wb.uimm;
            riscv_mw_pkg::res_csr:     o_riscv_mw_wbdata = wb.csrout;
            riscv_mw_pkg::res_sc:      o_riscv_mw_wbdata = wb.rddata_sc;
            default:                   o_riscv_mw_wbdata = '0;
        endcase
    end

    // no write on trap entry, x0 stays zero
    assign rf_we = wb.regw && !wb.gototrap && (wb.rdaddr != 5'd0);

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin
        if (i_riscv_mw_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[wb.rdaddr] <= o_riscv_mw_wbdata;
        end
    end

    // no bypass from the write port
    assign o_riscv_mw_rs1data = (i_riscv_mw_rs1addr == 5'd0) ? '0 : regs[i_riscv_mw_rs1addr];

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin
        if (i_riscv_mw_rst) begin
            o_riscv_mw_instret_count <= '0;
        end else if (wb.instret) begin
            o_riscv_mw_instret_count <= o_riscv_mw_instret_count + 1'b1;    // wraps
        end
    end

    assign o_riscv_mw_regwe_wb          = rf_we;
    assign o_riscv_mw_rdaddr_wb         = wb.rdaddr;
    assign o_riscv_mw_iscsr_wb          = wb.iscsr;     // to csr unit
    assign o_riscv_mw_gototrap_wb       = wb.gototrap;
    assign o_riscv_mw_returnfromtrap_wb = wb.returnfromtrap;
    assign o_riscv_mw_instret_wb        = wb.instret;

endmodule

`default_nettype wire

//--- verilog/riscv_mw_ppreg.sv
`default_nettype none

module riscv_mw_ppreg (
    input  logic                          i_riscv_mw_clk,
    input  logic                          i_riscv_mw_rst,
    input  logic                          i_riscv_mw_stall,
    input  logic                          i_riscv_mw_flush,    // trap redirect
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_pcplus4_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_result_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_uimm_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_memload_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_csrout_m,
    input  logic [riscv_mw_pkg::xlen-1:0] i_riscv_mw_rddata_sc_m,
    input  logic [4:0]                    i_riscv_mw_rdaddr_m,
    input  logic [2:0]                    i_riscv_mw_resultsrc_m,
    input  logic                          i_riscv_mw_regw_m,
    input  logic                          i_riscv_mw_iscsr_m,
    input  logic                          i_riscv_mw_gototrap_m,
    input  logic                          i_riscv_mw_returnfromtrap_m,
    input  logic                          i_riscv_mw_instret_m,
    riscv_mw_wb_if.stage                  wb
);

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin
        if (i_riscv_mw_rst) begin
            wb.pcplus4        <= '0;
            wb.result         <= '0;
            wb.uimm           <= '0;
            wb.memload        <= '0;
            wb.rdaddr         <= '0;
            wb.resultsrc      <= '0;
            wb.regw           <= 1'b0;
            wb.csrout         <= '0;
            wb.iscsr          <= 1'b0;
            wb.gototrap       <= 1'b0;
            wb.returnfromtrap <= 1'b0;
            wb.instret        <= 1'b0;
            wb.rddata_sc      <= '0;
        end else if (i_riscv_mw_flush) begin    // flush wins over stall
            wb.pcplus4        <= '0;
            wb.result         <= '0;
            wb.uimm           <= '0;
            wb.memload        <= '0;
            wb.rdaddr         <= '0;
            wb.resultsrc      <= '0;
            wb.regw           <= 1'b0;
            wb.csrout         <= '0;
            wb.iscsr          <= 1'b0;
            wb.gototrap       <= 1'b0;
            wb.returnfromtrap <= 1'b0;
            wb.instret        <= 1'b0;
            wb.rddata_sc      <= '0;
        end else if (!i_riscv_mw_stall) begin
            wb.pcplus4        <= i_riscv_mw_pcplus4_m;
            wb.result         <= i_riscv_mw_result_m;
            wb.uimm           <= i_riscv_mw_uimm_m;
            wb.memload        <= i_riscv_mw_memload_m;
            wb.rdaddr         <= i_riscv_mw_rdaddr_m;
            wb.resultsrc      <= i_riscv_mw_resultsrc_m;
            wb.regw           <= i_riscv_mw_regw_m;
            wb.csrout         <= i_riscv_mw_csrout_m;
            wb.iscsr          <= i_riscv_mw_iscsr_m;
            wb.gototrap       <= i_riscv_mw_gototrap_m;
            wb.returnfromtrap <= i_riscv_mw_returnfromtrap_m;
            wb.instret        <= i_riscv_mw_instret_m;
            wb.rddata_sc      <= i_riscv_mw_rddata_sc_m;
        end else begin
            // held instruction must not retire twice
            wb.instret        <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/riscv_mw_memdecode.sv
`default_nettype none

module riscv_mw_memdecode (
    input  riscv_mw_pkg::load_word_u       i_riscv_mw_memrdata_m,
    input  logic [2:0]                     i_riscv_mw_byteoff_m,
    input  logic [2:0]                     i_riscv_mw_loadsize_m,
    output logic [riscv_mw_pkg::xlen-1:0]  o_riscv_mw_memload_m
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] word_sel;

    // pick lanes, low offset bits ignored for wider accesses
    always_comb begin
        byte_sel = i_riscv_mw_memrdata_m.b[i_riscv_mw_byteoff_m];
        half_sel = i_riscv_mw_memrdata_m.h[i_riscv_mw_byteoff_m[2:1]];
        word_sel = i_riscv_mw_memrdata_m.w[i_riscv_mw_byteoff_m[2]];
    end

    always_comb begin
        case (i_riscv_mw_loadsize_m)
            riscv_mw_pkg::lb: begin
                o_riscv_mw_memload_m = {{(riscv_mw_pkg::xlen-8){byte_sel[7]}}, byte_sel};
            end
            riscv_mw_pkg::lh: begin
                o_riscv_mw_memload_m = {{(riscv_mw_pkg::xlen-16){half_sel[15]}}, half_sel};
            end
            riscv_mw_pkg::lw: begin
                o_riscv_mw_memload_m = {{(riscv_mw_pkg::xlen-32){word_sel[31]}}, word_sel};
            end
            riscv_mw_pkg::ld: begin
                o_riscv_mw_memload_m = i_riscv_mw_memrdata_m;
            end
            riscv_mw_pkg::lbu: begin
                o_riscv_mw_memload_m = {{(riscv_mw_pkg::xlen-8){1'b0}}, byte_sel};
            end
            riscv_mw_pkg::lhu: begin
                o_riscv_mw_memload_m = {{(riscv_mw_pkg::xlen-16){1'b0}}, half_sel};
            end
            riscv_mw_pkg::lwu: begin
                o_riscv_mw_memload_m = {{(riscv_mw_pkg::xlen-32){1'b0}}, word_sel};
            end
            default: begin
                o_riscv_mw_memload_m = i_riscv_mw_memrdata_m;    // code 7 read as ld
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/riscv_mw_wb_if.sv
`default_nettype none

interface riscv_mw_wb_if;

    logic [riscv_mw_pkg::xlen-1:0] pcplus4;
    logic [riscv_mw_pkg::xlen-1:0] result;
    logic [riscv_mw_pkg::xlen-1:0] uimm;
    logic [riscv_mw_pkg::xlen-1:0] memload;
    logic [4:0]                    rdaddr;
    logic [2:0]                    resultsrc;
    logic                          regw;
    logic [riscv_mw_pkg::xlen-1:0] csrout;
    logic                          iscsr;
    logic                          gototrap;
    logic                          returnfromtrap;
    logic                          instret;         // one per retired instr
    logic [riscv_mw_pkg::xlen-1:0] rddata_sc;

    // stage register side
    modport stage (
        output pcplus4, result, uimm, memload,
        output rdaddr, resultsrc, regw, csrout,
        output iscsr, gototrap, returnfromtrap,
        output instret, rddata_sc
    );

    // writeback side
    modport wb (
        input pcplus4, result, uimm, memload,
        input rdaddr, resultsrc, regw, csrout,
        input iscsr, gototrap, returnfromtrap,
        input instret, rddata_sc
    );

endinterface

`default_nettype wire

//--- verilog/riscv_mw_pkg.sv
`default_nettype none

package riscv_mw_pkg;

    localparam int xlen = 64;

    // writeback result source
    localparam logic [2:0] res_alu     = 3'd0;
    localparam logic [2:0] res_load    = 3'd1;
    localparam logic [2:0] res_pcplus4 = 3'd2;
    localparam logic [2:0] res_uimm    = 3'd3;
    localparam logic [2:0] res_csr     = 3'd4;
    localparam logic [2:0] res_sc      = 3'd5;    // 6 and 7 give zero

    // load size, funct3 encoding
    localparam logic [2:0] lb  = 3'd0;
    localparam logic [2:0] lh  = 3'd1;
    localparam logic [2:0] lw  = 3'd2;
    localparam logic [2:0] ld  = 3'd3;
    localparam logic [2:0] lbu = 3'd4;
    localparam logic [2:0] lhu = 3'd5;
    localparam logic [2:0] lwu = 3'd6;

    // one memory doubleword seen at three granularities
    typedef union packed {
        logic [7:0][7:0]  b;    // bytes
        logic [3:0][15:0] h;    // halfwords
        logic [1:0][31:0] w;    // words
    } load_word_u;

endpackage

`default_nettype wire
